/* oramPkg.sv */
/*
 * Shared types and tree geometry for the Path ORAM back end.
 * Imported by the controller modules and the testbench.
 */
package oramPkg;

	// --------------------------------------------------
	// DRAM command codes
	// --------------------------------------------------

	// Same encoding as the memory controller user interface
	typedef enum logic [2:0] {
		CmdWrite = 3'd0,
		CmdRead  = 3'd1
	} dramCmd_e;

	// --------------------------------------------------
	// Controller state
	// --------------------------------------------------

	// Reset lands in StInitialize
	typedef enum logic {
		StInitialize = 1'b0,
		StNormal     = 1'b1
	} oramState_e;

	// --------------------------------------------------
	// Tree geometry
	// --------------------------------------------------

	// Buckets in a full tree with leafBits-wide labels
	function automatic int bucketCount(input int leafBits);
		return (1 << (leafBits + 1)) - 1;
	endfunction

	// Heap index of the path bucket at one level
	// Level 0 is the root, level leafBits holds the leaf itself
	function automatic int pathBucket(input int leafBits, input int level, input int leaf);
		return (1 << level) - 1 + (leaf >> (leafBits - level));
	endfunction

endpackage

/* dramInitializer.sv */
/*
 * Fills every bucket of the ORAM tree with zeroed dummy blocks after reset.
 * Drives both the DRAM command and write channels, then raises Done.
 */
module dramInitializer import oramPkg::*; #(
	parameter int ORAML       = 3,
	parameter int ORAMZ       = 4,
	parameter int BlockBursts = 2,
	parameter int DDRAWidth   = 16,
	parameter int DDRDWidth   = 64
) (
	input  logic                   Clock,
	input  logic                   arstN,

	output logic [DDRAWidth-1:0]   DRAMCommandAddress,
	output dramCmd_e               DRAMCommand,
	output logic                   DRAMCommandValid,
	input  logic                   DRAMCommandReady,

	output logic [DDRDWidth-1:0]   DRAMWriteData,
	output logic [DDRDWidth/8-1:0] DRAMWriteMask,
	output logic                   DRAMWriteDataValid,
	input  logic                   DRAMWriteDataReady,

	output logic                   Done
);

	// --------------------------------------------------
	// Geometry
	// --------------------------------------------------

	localparam int MaskWidth    = DDRDWidth / 8;
	localparam int BucketBursts = ORAMZ * BlockBursts;
	localparam int TotalBursts  = bucketCount(ORAML) * BucketBursts;

	// Address of the final burst in the tree
	localparam logic [DDRAWidth-1:0] LastBurst = DDRAWidth'(TotalBursts - 1);

	logic [DDRAWidth-1:0] cmdCount;
	logic [DDRAWidth-1:0] dataCount;
	logic                 cmdDone;
	logic                 dataDone;
	logic                 cmdLast;
	logic                 dataLast;

	// Final transfer of each stream on this edge
	assign cmdLast  = DRAMCommandValid && DRAMCommandReady && (cmdCount == LastBurst);
	assign dataLast = DRAMWriteDataValid && DRAMWriteDataReady && (dataCount == LastBurst);

	// --------------------------------------------------
	// Command stream
	// --------------------------------------------------

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			cmdCount         <= '0;
			cmdDone          <= 1'b0;
			DRAMCommandValid <= 1'b0;
		end else if (!cmdDone) begin
			// First clock out of reset starts the stream
			if (!DRAMCommandValid) begin
				DRAMCommandValid <= 1'b1;
			end else if (DRAMCommandReady) begin
				if (cmdLast) begin
					DRAMCommandValid <= 1'b0;
					cmdDone          <= 1'b1;
				end else begin
					cmdCount <= cmdCount + 1'b1;
				end
			end
		end
	end

	// One write per burst address, in order
	assign DRAMCommandAddress = cmdCount;
	assign DRAMCommand        = CmdWrite;

	// --------------------------------------------------
	// Write data stream
	// --------------------------------------------------

	// Runs independently of the command stream
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			dataCount          <= '0;
			dataDone           <= 1'b0;
			DRAMWriteDataValid <= 1'b0;
		end else if (!dataDone) begin
			if (!DRAMWriteDataValid) begin
				DRAMWriteDataValid <= 1'b1;
			end else if (DRAMWriteDataReady) begin
				if (dataLast) begin
					DRAMWriteDataValid <= 1'b0;
					dataDone           <= 1'b1;
				end else begin
					dataCount <= dataCount + 1'b1;
				end
			end
		end
	end

	// Dummy blocks are all zero
	// Zero mask enables every byte
	assign DRAMWriteData = '0;
	assign DRAMWriteMask = MaskWidth'(0);

	// --------------------------------------------------
	// Completion
	// --------------------------------------------------

	// Sticky, set on the edge of the later final transfer
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			Done <= 1'b0;
		end else if ((cmdDone || cmdLast) && (dataDone || dataLast)) begin
			Done <= 1'b1;
		end
	end

endmodule

/* pathAddrGen.sv */
/*
 * Turns one accepted leaf label into the DRAM read commands for its path.
 * Walks root to leaf, every burst of every bucket, one command per ready cycle.
 */
module pathAddrGen import oramPkg::*; #(
	parameter int ORAML       = 3,
	parameter int ORAMZ       = 4,
	parameter int BlockBursts = 2,
	parameter int DDRAWidth   = 16
) (
	input  logic                 Clock,
	input  logic                 arstN,
	input  logic                 Enable,

	// Leaf request
	input  logic [ORAML-1:0]     AccessLeaf,
	input  logic                 AccessValid,
	output logic                 AccessReady,

	// DRAM command channel
	output logic [DDRAWidth-1:0] DRAMCommandAddress,
	output dramCmd_e             DRAMCommand,
	output logic                 DRAMCommandValid,
	input  logic                 DRAMCommandReady
);

	// --------------------------------------------------
	// Geometry and local types
	// --------------------------------------------------

	localparam int BucketBursts = ORAMZ * BlockBursts;
	localparam int LevelWidth   = $clog2(ORAML + 2);
	localparam int BurstWidth   = $clog2(BucketBursts + 1);

	localparam logic [LevelWidth-1:0] LastLevel = LevelWidth'(ORAML);
	localparam logic [BurstWidth-1:0] LastBurst = BurstWidth'(BucketBursts - 1);

	typedef enum logic {
		GenIdle  = 1'b0,
		GenIssue = 1'b1
	} genState_e;

	genState_e             state;
	logic [ORAML-1:0]      leafReg;
	logic [LevelWidth-1:0] level;
	logic [BurstWidth-1:0] burst;
	logic                  accept;
	logic                  cmdXfer;
	int                    bucketIdx;

	assign accept  = AccessValid && AccessReady;
	assign cmdXfer = DRAMCommandValid && DRAMCommandReady;

	// --------------------------------------------------
	// Path walk
	// --------------------------------------------------

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state <= GenIdle;
			level <= '0;
			burst <= '0;
		end else begin
			case (state)
				GenIdle: begin
					if (accept) begin
						state <= GenIssue;
						level <= '0;
						burst <= '0;
					end
				end
				GenIssue: begin
					// Stall in place without ready
					if (cmdXfer) begin
						if (burst == LastBurst) begin
							burst <= '0;
							if (level == LastLevel) begin
								state <= GenIdle;
							end else begin
								level <= level + 1'b1;
							end
						end else begin
							burst <= burst + 1'b1;
						end
					end
				end
				default: state <= GenIdle;
			endcase
		end
	end

	// Leaf is held for the whole walk
	always_ff @(posedge Clock) begin
		if (accept) begin
			leafReg <= AccessLeaf;
		end
	end

	// --------------------------------------------------
	// Outputs
	// --------------------------------------------------

	// Only take a new leaf when idle and the tree is initialized
	assign AccessReady      = (state == GenIdle) && Enable;
	assign DRAMCommandValid = (state == GenIssue);
	assign DRAMCommand      = CmdRead;

	// Bucket base plus burst offset
	always_comb begin
		bucketIdx          = pathBucket(ORAML, int'(level), int'(leafReg));
		DRAMCommandAddress = DDRAWidth'(bucketIdx * BucketBursts + int'(burst));
	end

endmodule

/* pathOram.sv */
/*
 * Path ORAM back end top level. Initializes the tree in DRAM,
 * then issues path reads for each leaf accepted on the access channel.
 */
module pathOram import oramPkg::*; #(
	parameter int ORAML       = 3,
	parameter int ORAMZ       = 4,
	parameter int BlockBursts = 2,
	parameter int DDRAWidth   = 16,
	parameter int DDRDWidth   = 64
) (
	input  logic                   Clock,
	input  logic                   arstN,

	// Access channel
	input  logic [ORAML-1:0]       AccessLeaf,
	input  logic                   AccessValid,
	output logic                   AccessReady,

	output logic                   InitDone,

	// DRAM command channel
	output logic [DDRAWidth-1:0]   DRAMCommandAddress,
	output dramCmd_e               DRAMCommand,
	output logic                   DRAMCommandValid,
	input  logic                   DRAMCommandReady,

	// DRAM write channel
	output logic [DDRDWidth-1:0]   DRAMWriteData,
	output logic [DDRDWidth/8-1:0] DRAMWriteMask,
	output logic                   DRAMWriteDataValid,
	input  logic                   DRAMWriteDataReady
);

	oramState_e state;
	logic       stInit;

	logic [DDRAWidth-1:0] initCmdAddress;
	dramCmd_e             initCmd;
	logic                 initCmdValid;
	logic                 initCmdReady;
	logic                 initWriteReady;
	logic                 initDoneRaw;

	logic [DDRAWidth-1:0] genCmdAddress;
	dramCmd_e             genCmd;
	logic                 genCmdValid;
	logic                 genCmdReady;

	// --------------------------------------------------
	// Controller
	// --------------------------------------------------

	// Leaves StInitialize once and stays in StNormal
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state <= StInitialize;
		end else if (state == StInitialize && initDoneRaw) begin
			state <= StNormal;
		end
	end

	assign stInit   = (state == StInitialize);
	assign InitDone = (state == StNormal);

	// --------------------------------------------------
	// DRAM channel ownership
	// --------------------------------------------------

	// Command channel belongs to the initializer until StNormal
	assign DRAMCommandAddress = stInit ? initCmdAddress : genCmdAddress;
	assign DRAMCommand        = stInit ? initCmd : genCmd;
	assign DRAMCommandValid   = stInit ? initCmdValid : genCmdValid;

	// Ready only reaches the current owner
	assign initCmdReady   = DRAMCommandReady && stInit;
	assign genCmdReady    = DRAMCommandReady && !stInit;
	assign initWriteReady = DRAMWriteDataReady && stInit;

	// --------------------------------------------------
	// Sub-blocks
	// --------------------------------------------------

	dramInitializer #(
		.ORAML      (ORAML),
		.ORAMZ      (ORAMZ),
		.BlockBursts(BlockBursts),
		.DDRAWidth  (DDRAWidth),
		.DDRDWidth  (DDRDWidth)
	) dramInit (
		.Clock             (Clock),
		.arstN             (arstN),
		.DRAMCommandAddress(initCmdAddress),
		.DRAMCommand       (initCmd),
		.DRAMCommandValid  (initCmdValid),
		.DRAMCommandReady  (initCmdReady),
		.DRAMWriteData     (DRAMWriteData),
		.DRAMWriteMask     (DRAMWriteMask),
		.DRAMWriteDataValid(DRAMWriteDataValid),
		.DRAMWriteDataReady(initWriteReady),
		.Done              (initDoneRaw)
	);

	// Enabled only after the tree is initialized
	pathAddrGen #(
		.ORAML      (ORAML),
		.ORAMZ      (ORAMZ),
		.BlockBursts(BlockBursts),
		.DDRAWidth  (DDRAWidth)
	) addrGen (
		.Clock             (Clock),
		.arstN             (arstN),
		.Enable            (InitDone),
		.AccessLeaf        (AccessLeaf),
		.AccessValid       (AccessValid),
		.AccessReady       (AccessReady),
		.DRAMCommandAddress(genCmdAddress),
		.DRAMCommand       (genCmd),
		.DRAMCommandValid  (genCmdValid),
		.DRAMCommandReady  (genCmdReady)
	);

endmodule

/* pathOram_checker.sv */
/*
 * Protocol assertions for the Path ORAM back end, bound to pathOram.
 */
module pathOram_checker import oramPkg::*; #(
	parameter int DDRAWidth = 16,
	parameter int DDRDWidth = 64
) (
	input logic                 Clock,
	input logic                 arstN,
	input logic                 AccessReady,
	input logic                 InitDone,
	input logic [DDRAWidth-1:0] DRAMCommandAddress,
	input dramCmd_e             DRAMCommand,
	input logic                 DRAMCommandValid,
	input logic                 DRAMCommandReady,
	input logic [DDRDWidth-1:0] DRAMWriteData,
	input logic                 DRAMWriteDataValid,
	input logic                 DRAMWriteDataReady
);

	timeunit 1ns;
	timeprecision 100ps;

	// Stalled command holds valid, address and code
	cmdHold: assert property (@(posedge Clock) disable iff (!arstN)
		DRAMCommandValid && !DRAMCommandReady |=>
			DRAMCommandValid && $stable(DRAMCommandAddress) && $stable(DRAMCommand))
		else $error("DRAM command changed while stalled");

	// Same rule on the write channel
	writeHold: assert property (@(posedge Clock) disable iff (!arstN)
		DRAMWriteDataValid && !DRAMWriteDataReady |=>
			DRAMWriteDataValid && $stable(DRAMWriteData))
		else $error("DRAM write data changed while stalled");

	// Both channels quiet under reset
	resetQuiet: assert property (@(posedge Clock)
		!arstN |-> !DRAMCommandValid && !DRAMWriteDataValid)
		else $error("DRAM valid high during reset");

	// No leaf accepted before the tree is filled
	accessGate: assert property (@(posedge Clock) disable iff (!arstN)
		AccessReady |-> InitDone)
		else $error("AccessReady high before InitDone");

	// Write channel idle once the tree is filled
	writeQuiet: assert property (@(posedge Clock) disable iff (!arstN)
		InitDone |-> !DRAMWriteDataValid)
		else $error("DRAM write valid high after InitDone");

endmodule

/* tbPathOram.sv */
/*
 * Testbench for the Path ORAM back end. Checks tree initialization under steady and
 * random DRAM ready, then replays the path accesses listed in pathOram_stim.txt.
 */
module tbPathOram import oramPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ORAML        = 3;
	localparam int ORAMZ        = 4;
	localparam int BlockBursts  = 2;
	localparam int DDRAWidth    = 16;
	localparam int DDRDWidth    = 64;
	localparam int BucketBursts = ORAMZ * BlockBursts;
	localparam int PathBursts   = (ORAML + 1) * BucketBursts;
	localparam int WaitLimit    = 4000;

	logic                   Clock;
	logic                   arstN;
	logic [ORAML-1:0]       AccessLeaf;
	logic                   AccessValid;
	logic                   AccessReady;
	logic                   InitDone;
	logic [DDRAWidth-1:0]   DRAMCommandAddress;
	dramCmd_e               DRAMCommand;
	logic                   DRAMCommandValid;
	logic                   DRAMCommandReady;
	logic [DDRDWidth-1:0]   DRAMWriteData;
	logic [DDRDWidth/8-1:0] DRAMWriteMask;
	logic                   DRAMWriteDataValid;
	logic                   DRAMWriteDataReady;

	// Values applied to the access channel on the next step
	logic                   driveValid;
	logic [ORAML-1:0]       driveLeaf;
	bit                     randomReady;
	logic [31:0]            lcgState;

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	pathOram #(
		.ORAML      (ORAML),
		.ORAMZ      (ORAMZ),
		.BlockBursts(BlockBursts),
		.DDRAWidth  (DDRAWidth),
		.DDRDWidth  (DDRDWidth)
	) UUT (.*);

	bind pathOram pathOram_checker #(
		.DDRAWidth(DDRAWidth),
		.DDRDWidth(DDRDWidth)
	) protocolCheck (
		.Clock             (Clock),
		.arstN             (arstN),
		.AccessReady       (AccessReady),
		.InitDone          (InitDone),
		.DRAMCommandAddress(DRAMCommandAddress),
		.DRAMCommand       (DRAMCommand),
		.DRAMCommandValid  (DRAMCommandValid),
		.DRAMCommandReady  (DRAMCommandReady),
		.DRAMWriteData     (DRAMWriteData),
		.DRAMWriteDataValid(DRAMWriteDataValid),
		.DRAMWriteDataReady(DRAMWriteDataReady)
	);

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------

	// LCG step, lowest bit of the upper half is the output
	function automatic bit nextRandomBit();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[16];
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "%s", reason);
	endtask

	task automatic checkValue(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			abortRun($sformatf("CHECK FAILED %s expected %0h actual %0h", name, expected, actual));
		end
	endtask

	// One clock: drive just after the edge, sample at mid-cycle
	task automatic stepCycle();
		@(posedge Clock);
		#1;
		AccessValid = driveValid;
		AccessLeaf  = driveLeaf;
		if (randomReady) begin
			DRAMCommandReady   = nextRandomBit();
			DRAMWriteDataReady = nextRandomBit();
		end else begin
			DRAMCommandReady   = 1'b1;
			DRAMWriteDataReady = 1'b1;
		end
		@(negedge Clock);
	endtask

	task automatic applyReset();
		@(posedge Clock);
		#1;
		arstN = 1'b0;
		repeat (8) @(posedge Clock);
		#1;
		arstN = 1'b1;
		@(negedge Clock);
	endtask

	// Sum of 2^level over all tree levels
	function automatic int treeBuckets();
		int total;
		total = 0;
		for (int lvl = 0; lvl <= ORAML; lvl++) begin
			total += 1 << lvl;
		end
		return total;
	endfunction

	// --------------------------------------------------
	// Initialization
	// --------------------------------------------------

	task automatic checkInit(input bit randomMode);
		int totalBursts;
		int cmdSeen;
		int dataSeen;
		int cycles;
		totalBursts = treeBuckets() * BucketBursts;
		cmdSeen     = 0;
		dataSeen    = 0;
		cycles      = 0;
		randomReady = randomMode;
		// A leaf is offered the whole time and must be refused
		driveValid  = 1'b1;
		driveLeaf   = '1;
		applyReset();
		while (cmdSeen < totalBursts || dataSeen < totalBursts) begin
			stepCycle();
			cycles++;
			if (cycles > WaitLimit) begin
				abortRun("Timeout waiting for the initialization writes to finish");
			end
			checkValue("init AccessReady", 64'(0), 64'(AccessReady));
			checkValue("init InitDone", 64'(0), 64'(InitDone));
			// Each stream stops after its last transfer
			if (cmdSeen == totalBursts) begin
				checkValue("extra init command", 64'(0), 64'(DRAMCommandValid));
			end
			if (dataSeen == totalBursts) begin
				checkValue("extra init write", 64'(0), 64'(DRAMWriteDataValid));
			end
			if (DRAMCommandValid && DRAMCommandReady) begin
				checkValue("init command", 64'(CmdWrite), 64'(DRAMCommand));
				checkValue("init address", 64'(cmdSeen), 64'(DRAMCommandAddress));
				cmdSeen++;
			end
			if (DRAMWriteDataValid && DRAMWriteDataReady) begin
				checkValue("init write data", 64'(0), 64'(DRAMWriteData));
				checkValue("init write mask", 64'(0), 64'(DRAMWriteMask));
				dataSeen++;
			end
		end
		driveValid = 1'b0;
		// Done one edge later, StNormal on the edge after
		cycles = 0;
		while (!InitDone) begin
			stepCycle();
			cycles++;
			if (cycles > WaitLimit) begin
				abortRun("Timeout waiting for InitDone");
			end
			checkValue("extra init command", 64'(0), 64'(DRAMCommandValid));
			checkValue("extra init write", 64'(0), 64'(DRAMWriteDataValid));
		end
		checkValue("InitDone latency", 64'(2), 64'(cycles));
		checkValue("AccessReady after InitDone", 64'(1), 64'(AccessReady));
	endtask

	// --------------------------------------------------
	// Path access
	// --------------------------------------------------

	task automatic runAccess(input int leaf, input bit randomMode, input int deepest,
			input int lineNo);
		int    path [0:ORAML];
		int    expectedAddr [$];
		int    node;
		int    sent;
		int    cycles;
		string tag;
		tag     = $sformatf("line %0d", lineNo);
		node    = 0;
		path[0] = 0;
		// Heap walk, left child on a 0 bit, MSB of the leaf first
		for (int lvl = 1; lvl <= ORAML; lvl++) begin
			node      = 2 * node + 1 + ((leaf >> (ORAML - lvl)) & 1);
			path[lvl] = node;
		end
		checkValue({tag, " deepest bucket"}, 64'(deepest), 64'(path[ORAML]));
		for (int lvl = 0; lvl <= ORAML; lvl++) begin
			for (int b = 0; b < BucketBursts; b++) begin
				expectedAddr.push_back(path[lvl] * BucketBursts + b);
			end
		end
		randomReady = randomMode;
		driveLeaf   = ORAML'(leaf);
		driveValid  = 1'b1;
		cycles      = 0;
		do begin
			stepCycle();
			cycles++;
			if (cycles > WaitLimit) begin
				abortRun($sformatf("Timeout waiting for AccessReady on stim line %0d", lineNo));
			end
			checkValue({tag, " idle command valid"}, 64'(0), 64'(DRAMCommandValid));
		end while (!(AccessValid && AccessReady));
		// Leaf must be latched, so scramble it after the accept
		driveValid = 1'b0;
		driveLeaf  = ~ORAML'(leaf);
		sent       = 0;
		cycles     = 0;
		while (sent < PathBursts) begin
			stepCycle();
			cycles++;
			if (cycles > WaitLimit) begin
				abortRun($sformatf("Timeout waiting for path reads on stim line %0d", lineNo));
			end
			if (cycles == 1) begin
				checkValue({tag, " first read valid"}, 64'(1), 64'(DRAMCommandValid));
			end
			checkValue({tag, " busy AccessReady"}, 64'(0), 64'(AccessReady));
			checkValue({tag, " write valid"}, 64'(0), 64'(DRAMWriteDataValid));
			if (DRAMCommandValid && DRAMCommandReady) begin
				checkValue({tag, " read command"}, 64'(CmdRead), 64'(DRAMCommand));
				checkValue({tag, " read address"}, 64'(expectedAddr[sent]),
					64'(DRAMCommandAddress));
				sent++;
			end
		end
		// Turnaround is a single cycle
		stepCycle();
		checkValue({tag, " AccessReady after path"}, 64'(1), 64'(AccessReady));
		checkValue({tag, " command valid after path"}, 64'(0), 64'(DRAMCommandValid));
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------

	initial begin
		int    fd;
		int    leaf;
		int    mode;
		int    deepest;
		int    lineNo;
		int    accesses;
		string line;
		arstN              = 1'b0;
		AccessLeaf         = '0;
		AccessValid        = 1'b0;
		DRAMCommandReady   = 1'b0;
		DRAMWriteDataReady = 1'b0;
		driveValid         = 1'b0;
		driveLeaf          = '0;
		randomReady        = 1'b0;
		lcgState           = 32'hb8f4_9b48;
		checkInit(1'b0);
		checkInit(1'b1);
		fd = $fopen("pathOram_stim.txt", "r");
		if (fd == 0) begin
			abortRun("Could not open pathOram_stim.txt");
		end
		lineNo   = 0;
		accesses = 0;
		while ($fgets(line, fd) > 0) begin
			lineNo++;
			// Skip blanks and comment lines
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			if ($sscanf(line, "%d %d %d", leaf, mode, deepest) != 3) begin
				abortRun($sformatf("Stim line %0d is not three numbers", lineNo));
			end
			runAccess(leaf, mode != 0, deepest, lineNo);
			accesses++;
		end
		$fclose(fd);
		if (accesses == 0) begin
			abortRun("The stim file held no accesses");
		end
		$display("Test passed");
		$finish;
	end

endmodule

/* pathOram_stim.txt */
# leaf  mode (0 steady ready, 1 random ready)  expected deepest bucket index
# decimal columns, one path access per line
0 0 7
7 0 14
3 0 10
4 0 11
5 1 12
2 1 9
6 1 13
1 1 8
0 1 7
7 1 14
1 0 8
6 0 13
2 0 9
5 0 12
4 1 11
3 1 10
3 1 10
0 0 7
7 1 14
5 0 12
6 1 13

/* tb.f */
oramPkg.sv
dramInitializer.sv
pathAddrGen.sv
pathOram.sv
pathOram_checker.sv
tbPathOram.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tbPathOram
FILELIST  := tb.f
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps
LINTFLAGS := --lint-only -Wall --timing --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
